// File: design/decode_top.sv
`timescale 1ns/10ps
`default_nettype none

module decode_top #(
    parameter int NUM_REGS = 32
) (
    input  logic                       clk,
    input  logic                       rst,
    input  rv32i_pipe_pkg::if_id_rec_t i_if_id,
    input  logic                       i_imem_resp,
    input  rv32i_isa_pkg::word_t       i_imem_rdata,
    input  rv32i_isa_pkg::reg_sel_t    i_wb_rd_s,
    input  rv32i_isa_pkg::word_t       i_wb_rd_v,
    input  logic                       i_wb_regf_we,
    input  rv32i_isa_pkg::reg_sel_t    i_ex_rd_s,
    input  rv32i_isa_pkg::word_t       i_ex_rd_v,
    input  logic                       i_ex_regf_we,
    input  logic                       i_flush,
    output rv32i_pipe_pkg::id_ex_rec_t o_id_ex,
    output logic                       o_stall
);

    rv32i_isa_pkg::reg_sel_t  rs1_s;
    rv32i_isa_pkg::reg_sel_t  rs2_s;
    rv32i_isa_pkg::word_t     rs1_v;
    rv32i_isa_pkg::word_t     rs2_v;
    rv32i_pipe_pkg::fwd_sel_t fwd1;
    rv32i_pipe_pkg::fwd_sel_t fwd2;

    id_stage u_id_stage (
        .clk          (clk),
        .rst          (rst),
        .i_if_id      (i_if_id),
        .i_imem_resp  (i_imem_resp),
        .i_imem_rdata (i_imem_rdata),
        .i_stall      (o_stall),
        .i_flush      (i_flush),
        .i_fwd1       (fwd1),
        .i_fwd2       (fwd2),
        .i_ex_rd_v    (i_ex_rd_v),
        .i_rs1_v      (rs1_v),
        .i_rs2_v      (rs2_v),
        .o_rs1_s      (rs1_s),
        .o_rs2_s      (rs2_s),
        .o_id_ex      (o_id_ex)
    );

    regfile #(
        .NUM_REGS (NUM_REGS)
    ) u_regfile (
        .clk     (clk),
        .rst     (rst),
        .i_we    (i_wb_regf_we),
        .i_rd_s  (i_wb_rd_s),
        .i_rd_v  (i_wb_rd_v),
        .i_rs1_s (rs1_s),
        .i_rs2_s (rs2_s),
        .o_rs1_v (rs1_v),
        .o_rs2_v (rs2_v)
    );

    // Load-use check looks at the record now in ID/EX
    hazard_unit u_hazard_unit (
        .clk              (clk),
        .rst              (rst),
        .i_rs1_s          (rs1_s),
        .i_rs2_s          (rs2_s),
        .i_id_ex_rd_s     (o_id_ex.rd_s),
        .i_id_ex_mem_read (o_id_ex.mem.mem_read),
        .i_ex_rd_s        (i_ex_rd_s),
        .i_ex_regf_we     (i_ex_regf_we),
        .o_fwd1           (fwd1),
        .o_fwd2           (fwd2),
        .o_stall          (o_stall)
    );

endmodule

`default_nettype wire

// File: design/hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  rv32i_isa_pkg::reg_sel_t  i_rs1_s,
    input  rv32i_isa_pkg::reg_sel_t  i_rs2_s,
    input  rv32i_isa_pkg::reg_sel_t  i_id_ex_rd_s,
    input  logic                     i_id_ex_mem_read,
    input  rv32i_isa_pkg::reg_sel_t  i_ex_rd_s,
    input  logic                     i_ex_regf_we,
    output rv32i_pipe_pkg::fwd_sel_t o_fwd1,
    output rv32i_pipe_pkg::fwd_sel_t o_fwd2,
    output logic                     o_stall
);

    logic load_use;
    logic stall_q;
    logic ex_writes;

    // Load in ID/EX whose result the decoded instruction needs
    assign load_use = i_id_ex_mem_read && (i_id_ex_rd_s != '0)
                      && ((i_id_ex_rd_s == i_rs1_s) || (i_id_ex_rd_s == i_rs2_s));

    // One cycle only, the replay that follows must go through
    assign o_stall = load_use && !stall_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= o_stall;
        end
    end

    assign ex_writes = i_ex_regf_we && (i_ex_rd_s != '0);

    always_comb begin
        o_fwd1 = rv32i_pipe_pkg::fwd_regf;
        o_fwd2 = rv32i_pipe_pkg::fwd_regf;
        if (ex_writes && (i_ex_rd_s == i_rs1_s)) begin
            o_fwd1 = rv32i_pipe_pkg::fwd_ex;
        end
        if (ex_writes && (i_ex_rd_s == i_rs2_s)) begin
            o_fwd2 = rv32i_pipe_pkg::fwd_ex;
        end
    end

endmodule

`default_nettype wire

// File: design/id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  rv32i_pipe_pkg::if_id_rec_t i_if_id,
    input  logic                       i_imem_resp,
    input  rv32i_isa_pkg::word_t       i_imem_rdata,
    input  logic                       i_stall,
    input  logic                       i_flush,
    input  rv32i_pipe_pkg::fwd_sel_t   i_fwd1,
    input  rv32i_pipe_pkg::fwd_sel_t   i_fwd2,
    input  rv32i_isa_pkg::word_t       i_ex_rd_v,
    input  rv32i_isa_pkg::word_t       i_rs1_v,
    input  rv32i_isa_pkg::word_t       i_rs2_v,
    output rv32i_isa_pkg::reg_sel_t    o_rs1_s,
    output rv32i_isa_pkg::reg_sel_t    o_rs2_s,
    output rv32i_pipe_pkg::id_ex_rec_t o_id_ex
);

    rv32i_isa_pkg::word_t        held_word;
    rv32i_pipe_pkg::if_id_rec_t  held_fetch;
    logic                        replay_q;

    logic                        cur_valid;
    rv32i_isa_pkg::word_t        cur_word;
    rv32i_pipe_pkg::if_id_rec_t  cur_fetch;

    rv32i_isa_pkg::opcode_t      opcode;
    rv32i_isa_pkg::funct3_t      funct3;
    rv32i_isa_pkg::funct7_t      funct7;
    rv32i_isa_pkg::reg_sel_t     rd_s;
    rv32i_isa_pkg::word_t        imm_i;
    rv32i_isa_pkg::word_t        imm_s;
    rv32i_isa_pkg::word_t        imm_b;
    rv32i_isa_pkg::word_t        imm_u;
    rv32i_isa_pkg::word_t        imm_j;
    rv32i_isa_pkg::word_t        rs1_v;
    rv32i_isa_pkg::word_t        rs2_v;

    rv32i_pipe_pkg::ex_signal_t  ex_sig;
    rv32i_pipe_pkg::mem_signal_t mem_sig;
    rv32i_pipe_pkg::wb_signal_t  wb_sig;

    // Replay the held word in the cycle after a stall, unless flushed
    always_ff @(posedge clk) begin
        if (rst) begin
            replay_q <= 1'b0;
        end else begin
            replay_q <= i_stall && !i_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (i_imem_resp && !replay_q) begin
            held_word  <= i_imem_rdata;
            held_fetch <= i_if_id;
        end
    end

    // Replay wins over a new strobe, idle decodes as all zero
    assign cur_valid = replay_q || i_imem_resp;
    assign cur_word  = replay_q ? held_word : (i_imem_resp ? i_imem_rdata : '0);
    assign cur_fetch = replay_q ? held_fetch : (i_imem_resp ? i_if_id : '0);

    assign opcode  = rv32i_isa_pkg::opcode_t'(cur_word[6:0]);
    assign funct3  = cur_word[14:12];
    assign funct7  = cur_word[31:25];
    assign rd_s    = cur_word[11:7];
    assign o_rs1_s = cur_word[19:15];
    assign o_rs2_s = cur_word[24:20];

    assign imm_i = {{21{cur_word[31]}}, cur_word[30:20]};
    assign imm_s = {{21{cur_word[31]}}, cur_word[30:25], cur_word[11:7]};
    assign imm_b = {{20{cur_word[31]}}, cur_word[7], cur_word[30:25], cur_word[11:8], 1'b0};
    assign imm_u = {cur_word[31:12], 12'h000};
    assign imm_j = {{12{cur_word[31]}}, cur_word[19:12], cur_word[20], cur_word[30:21], 1'b0};

    assign rs1_v = (i_fwd1 == rv32i_pipe_pkg::fwd_ex) ? i_ex_rd_v : i_rs1_v;
    assign rs2_v = (i_fwd2 == rv32i_pipe_pkg::fwd_ex) ? i_ex_rd_v : i_rs2_v;

    always_comb begin
        // Zero defaults mean rs1, rs2, add and the ALU result
        ex_sig  = '0;
        mem_sig = '0;
        wb_sig  = '0;
        case (opcode)
            rv32i_isa_pkg::op_lui: begin
                wb_sig.regf_m_sel = rv32i_pipe_pkg::wb_u_imm;
                wb_sig.regf_we    = 1'b1;
            end
            rv32i_isa_pkg::op_auipc: begin
                ex_sig.alu_m1_sel = rv32i_pipe_pkg::m1_pc;
                ex_sig.alu_m2_sel = rv32i_pipe_pkg::m2_imm_u;
                wb_sig.regf_we    = 1'b1;
            end
            rv32i_isa_pkg::op_imm, rv32i_isa_pkg::op_reg: begin
                wb_sig.regf_we = 1'b1;
                if (opcode == rv32i_isa_pkg::op_imm) begin
                    ex_sig.alu_m2_sel = rv32i_pipe_pkg::m2_imm_i;
                    ex_sig.cmp_m_sel  = rv32i_pipe_pkg::cmp_m_imm_i;
                end
                case (funct3)
                    // slt and sltu go through the comparator
                    rv32i_isa_pkg::f3_slt: begin
                        ex_sig.cmp_op     = rv32i_pipe_pkg::cmp_blt;
                        wb_sig.regf_m_sel = rv32i_pipe_pkg::wb_br_en;
                    end
                    rv32i_isa_pkg::f3_sltu: begin
                        ex_sig.cmp_op     = rv32i_pipe_pkg::cmp_bltu;
                        wb_sig.regf_m_sel = rv32i_pipe_pkg::wb_br_en;
                    end
                    rv32i_isa_pkg::f3_sr: begin
                        ex_sig.alu_op = funct7[5] ? rv32i_pipe_pkg::alu_sra
                                                  : rv32i_pipe_pkg::alu_srl;
                    end
                    rv32i_isa_pkg::f3_add: begin
                        // Only the register form has sub
                        if ((opcode == rv32i_isa_pkg::op_reg) && funct7[5]) begin
                            ex_sig.alu_op = rv32i_pipe_pkg::alu_sub;
                        end
                    end
                    default: begin
                        ex_sig.alu_op = rv32i_pipe_pkg::alu_op_t'(funct3);
                    end
                endcase
            end
            rv32i_isa_pkg::op_load: begin
                ex_sig.alu_m2_sel = rv32i_pipe_pkg::m2_imm_i;
                mem_sig.mem_read  = 1'b1;
                mem_sig.load_op   = funct3;
                wb_sig.regf_we    = 1'b1;
                case (funct3)
                    rv32i_isa_pkg::f3_lb:  wb_sig.regf_m_sel = rv32i_pipe_pkg::wb_lb;
                    rv32i_isa_pkg::f3_lh:  wb_sig.regf_m_sel = rv32i_pipe_pkg::wb_lh;
                    rv32i_isa_pkg::f3_lw:  wb_sig.regf_m_sel = rv32i_pipe_pkg::wb_lw;
                    rv32i_isa_pkg::f3_lbu: wb_sig.regf_m_sel = rv32i_pipe_pkg::wb_lbu;
                    rv32i_isa_pkg::f3_lhu: wb_sig.regf_m_sel = rv32i_pipe_pkg::wb_lhu;
                    default:               wb_sig.regf_m_sel = rv32i_pipe_pkg::wb_alu;
                endcase
            end
            rv32i_isa_pkg::op_store: begin
                ex_sig.alu_m2_sel = rv32i_pipe_pkg::m2_imm_s;
                mem_sig.store_op  = funct3;
                // Byte, half and word stores only
                mem_sig.mem_write = (funct3 == rv32i_isa_pkg::f3_sb)
                                    || (funct3 == rv32i_isa_pkg::f3_sh)
                                    || (funct3 == rv32i_isa_pkg::f3_sw);
            end
            rv32i_isa_pkg::op_jal, rv32i_isa_pkg::op_jalr: begin
                wb_sig.regf_m_sel = rv32i_pipe_pkg::wb_pc_plus4;
                wb_sig.regf_we    = 1'b1;
            end
            rv32i_isa_pkg::op_br: begin
                ex_sig.cmp_op = rv32i_pipe_pkg::cmp_op_t'(funct3);
            end
            default: begin
            end
        endcase
    end

    // ID/EX register, a bubble on stall, flush or an idle cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            o_id_ex <= '0;
        end else if (i_stall || i_flush || !cur_valid) begin
            o_id_ex <= '0;
        end else begin
            o_id_ex.inst  <= cur_word;
            o_id_ex.fetch <= cur_fetch;
            o_id_ex.ex    <= ex_sig;
            o_id_ex.mem   <= mem_sig;
            o_id_ex.wb    <= wb_sig;
            o_id_ex.imm_i <= imm_i;
            o_id_ex.imm_s <= imm_s;
            o_id_ex.imm_b <= imm_b;
            o_id_ex.imm_u <= imm_u;
            o_id_ex.imm_j <= imm_j;
            o_id_ex.rs1_v <= rs1_v;
            o_id_ex.rs2_v <= rs2_v;
            o_id_ex.rs1_s <= o_rs1_s;
            o_id_ex.rs2_s <= o_rs2_s;
            o_id_ex.rd_s  <= rd_s;
        end
    end

endmodule

`default_nettype wire

// File: design/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile #(
    parameter int NUM_REGS = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_we,
    input  rv32i_isa_pkg::reg_sel_t i_rd_s,
    input  rv32i_isa_pkg::word_t    i_rd_v,
    input  rv32i_isa_pkg::reg_sel_t i_rs1_s,
    input  rv32i_isa_pkg::reg_sel_t i_rs2_s,
    output rv32i_isa_pkg::word_t    o_rs1_v,
    output rv32i_isa_pkg::word_t    o_rs2_v
);

    rv32i_isa_pkg::word_t regs [NUM_REGS];
    logic                 wr_en;

    // x0 and indices past the file are never written
    assign wr_en = i_we && (i_rd_s != '0) && (int'(i_rd_s) < NUM_REGS);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_rd_s] <= i_rd_v;
        end
    end

    // Same-cycle write is seen by the read
    function automatic rv32i_isa_pkg::word_t read_port(input rv32i_isa_pkg::reg_sel_t sel);
        rv32i_isa_pkg::word_t val;
        val = '0;
        if (wr_en && (sel == i_rd_s)) begin
            val = i_rd_v;
        end else if (int'(sel) < NUM_REGS) begin
            val = regs[sel];
        end
        return val;
    endfunction

    always_comb begin
        o_rs1_v = read_port(i_rs1_s);
        o_rs2_v = read_port(i_rs2_s);
    end

endmodule

`default_nettype wire

// File: design/rv32i_isa_pkg.sv
`default_nettype none

package rv32i_isa_pkg;

    // Widths that carry a meaning
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_sel_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [63:0] order_t;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011
    } opcode_t;

    // Integer function codes that need their own decode
    localparam funct3_t f3_add  = 3'b000;
    localparam funct3_t f3_slt  = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_sr   = 3'b101;

    // Load widths
    localparam funct3_t f3_lb  = 3'b000;
    localparam funct3_t f3_lh  = 3'b001;
    localparam funct3_t f3_lw  = 3'b010;
    localparam funct3_t f3_lbu = 3'b100;
    localparam funct3_t f3_lhu = 3'b101;

    // Store widths
    localparam funct3_t f3_sb = 3'b000;
    localparam funct3_t f3_sh = 3'b001;
    localparam funct3_t f3_sw = 3'b010;

endpackage

`default_nettype wire

// File: design/rv32i_pipe_pkg.sv
`default_nettype none

package rv32i_pipe_pkg;

    // Codes match funct3 except for sra and sub
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_t;

    // Comparator code is the branch funct3
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic {m1_rs1, m1_pc} alu_m1_sel_t;
    typedef enum logic [1:0] {m2_rs2, m2_imm_i, m2_imm_s, m2_imm_u} alu_m2_sel_t;
    typedef enum logic {cmp_m_rs2, cmp_m_imm_i} cmp_m_sel_t;

    // Write-back sources
    typedef enum logic [3:0] {
        wb_alu, wb_br_en, wb_u_imm, wb_pc_plus4, wb_lb, wb_lh, wb_lw, wb_lbu, wb_lhu
    } regf_m_sel_t;

    typedef enum logic {fwd_regf, fwd_ex} fwd_sel_t;

    typedef struct packed {
        alu_m1_sel_t alu_m1_sel;
        alu_m2_sel_t alu_m2_sel;
        alu_op_t     alu_op;
        cmp_m_sel_t  cmp_m_sel;
        cmp_op_t     cmp_op;
    } ex_signal_t;

    typedef struct packed {
        logic                   mem_read;
        logic                   mem_write;
        rv32i_isa_pkg::funct3_t load_op;
        rv32i_isa_pkg::funct3_t store_op;
    } mem_signal_t;

    typedef struct packed {
        regf_m_sel_t regf_m_sel;
        logic        regf_we;
    } wb_signal_t;

    typedef struct packed {
        rv32i_isa_pkg::word_t  pc;
        rv32i_isa_pkg::word_t  pc_next;
        rv32i_isa_pkg::order_t order;
        logic                  valid;
    } if_id_rec_t;

    typedef struct packed {
        rv32i_isa_pkg::word_t    inst;
        if_id_rec_t              fetch;
        ex_signal_t              ex;
        mem_signal_t             mem;
        wb_signal_t              wb;
        rv32i_isa_pkg::word_t    imm_i;
        rv32i_isa_pkg::word_t    imm_s;
        rv32i_isa_pkg::word_t    imm_b;
        rv32i_isa_pkg::word_t    imm_u;
        rv32i_isa_pkg::word_t    imm_j;
        rv32i_isa_pkg::word_t    rs1_v;
        rv32i_isa_pkg::word_t    rs2_v;
        rv32i_isa_pkg::reg_sel_t rs1_s;
        rv32i_isa_pkg::reg_sel_t rs2_s;
        rv32i_isa_pkg::reg_sel_t rd_s;
    } id_ex_rec_t;

endpackage

`default_nettype wire

// File: project.f
design/rv32i_isa_pkg.sv
design/rv32i_pipe_pkg.sv
design/regfile.sv
design/hazard_unit.sv
design/id_stage.sv
design/decode_top.sv
testbench/decode_checker.sv
testbench/tb_decode_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the decode front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_decode_top -f project.f -o tb_decode_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_decode_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -Fxq "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

// File: testbench/decode_checker.sv
`timescale 1ns/10ps
`default_nettype none

module decode_checker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [127:0]               i_name,
    input  logic                       i_row_active,
    input  logic                       i_exp_stall,
    input  rv32i_pipe_pkg::if_id_rec_t i_if_id,
    input  logic                       i_imem_resp,
    input  rv32i_isa_pkg::word_t       i_imem_rdata,
    input  rv32i_isa_pkg::reg_sel_t    i_wb_rd_s,
    input  rv32i_isa_pkg::word_t       i_wb_rd_v,
    input  logic                       i_wb_regf_we,
    input  rv32i_isa_pkg::reg_sel_t    i_ex_rd_s,
    input  rv32i_isa_pkg::word_t       i_ex_rd_v,
    input  logic                       i_ex_regf_we,
    input  logic                       i_flush,
    input  rv32i_pipe_pkg::id_ex_rec_t i_id_ex,
    input  logic                       i_stall,
    output int                         o_errors,
    output int                         o_checks
);

    rv32i_isa_pkg::word_t       shadow [32];
    rv32i_pipe_pkg::id_ex_rec_t exp_rec;
    rv32i_pipe_pkg::id_ex_rec_t cur_rec;
    logic [127:0]               exp_name;
    logic                       exp_row;
    logic                       replay;
    rv32i_isa_pkg::word_t       held_word;
    rv32i_pipe_pkg::if_id_rec_t held_fetch;
    rv32i_isa_pkg::word_t       cur_word;
    rv32i_pipe_pkg::if_id_rec_t cur_fetch;

    // Fields, immediates and control bundles straight from the RV32I encoding
    function automatic rv32i_pipe_pkg::id_ex_rec_t decode_rules(input rv32i_isa_pkg::word_t w);
        rv32i_pipe_pkg::id_ex_rec_t r;
        logic [2:0]                 f3;
        logic                       is_reg;
        r = '0;
        f3 = w[14:12];
        is_reg = (w[6:0] == 7'b0110011);
        r.inst = w;
        r.rs1_s = w[19:15];
        r.rs2_s = w[24:20];
        r.rd_s = w[11:7];
        r.imm_i = {{20{w[31]}}, w[31:20]};
        r.imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        r.imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        r.imm_u = {w[31:12], 12'h000};
        r.imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        case (w[6:0])
            7'b0110111: begin
                r.wb.regf_m_sel = rv32i_pipe_pkg::wb_u_imm;
                r.wb.regf_we = 1'b1;
            end
            7'b0010111: begin
                r.ex.alu_m1_sel = rv32i_pipe_pkg::m1_pc;
                r.ex.alu_m2_sel = rv32i_pipe_pkg::m2_imm_u;
                r.wb.regf_we = 1'b1;
            end
            7'b0010011, 7'b0110011: begin
                r.wb.regf_we = 1'b1;
                if (!is_reg) begin
                    r.ex.alu_m2_sel = rv32i_pipe_pkg::m2_imm_i;
                    r.ex.cmp_m_sel = rv32i_pipe_pkg::cmp_m_imm_i;
                end
                case (f3)
                    3'b000: r.ex.alu_op = (is_reg && w[30]) ? rv32i_pipe_pkg::alu_sub
                                                             : rv32i_pipe_pkg::alu_add;
                    3'b001: r.ex.alu_op = rv32i_pipe_pkg::alu_sll;
                    3'b010: begin
                        r.ex.cmp_op = rv32i_pipe_pkg::cmp_blt;
                        r.wb.regf_m_sel = rv32i_pipe_pkg::wb_br_en;
                    end
                    3'b011: begin
                        r.ex.cmp_op = rv32i_pipe_pkg::cmp_bltu;
                        r.wb.regf_m_sel = rv32i_pipe_pkg::wb_br_en;
                    end
                    3'b100: r.ex.alu_op = rv32i_pipe_pkg::alu_xor;
                    3'b101: r.ex.alu_op = w[30] ? rv32i_pipe_pkg::alu_sra
                                                : rv32i_pipe_pkg::alu_srl;
                    3'b110: r.ex.alu_op = rv32i_pipe_pkg::alu_or;
                    default: r.ex.alu_op = rv32i_pipe_pkg::alu_and;
                endcase
            end
            7'b0000011: begin
                r.ex.alu_m2_sel = rv32i_pipe_pkg::m2_imm_i;
                r.mem.mem_read = 1'b1;
                r.mem.load_op = f3;
                r.wb.regf_we = 1'b1;
                case (f3)
                    3'b000: r.wb.regf_m_sel = rv32i_pipe_pkg::wb_lb;
                    3'b001: r.wb.regf_m_sel = rv32i_pipe_pkg::wb_lh;
                    3'b010: r.wb.regf_m_sel = rv32i_pipe_pkg::wb_lw;
                    3'b100: r.wb.regf_m_sel = rv32i_pipe_pkg::wb_lbu;
                    3'b101: r.wb.regf_m_sel = rv32i_pipe_pkg::wb_lhu;
                    default: r.wb.regf_m_sel = rv32i_pipe_pkg::wb_alu;
                endcase
            end
            7'b0100011: begin
                r.ex.alu_m2_sel = rv32i_pipe_pkg::m2_imm_s;
                r.mem.store_op = f3;
                r.mem.mem_write = (f3 < 3'b011);
            end
            7'b1101111, 7'b1100111: begin
                r.wb.regf_m_sel = rv32i_pipe_pkg::wb_pc_plus4;
                r.wb.regf_we = 1'b1;
            end
            7'b1100011: r.ex.cmp_op = rv32i_pipe_pkg::cmp_op_t'(f3);
            default: begin
            end
        endcase
        return r;
    endfunction

    // EX result first, then a same-cycle write-back, then the shadow file
    function automatic rv32i_isa_pkg::word_t operand(input rv32i_isa_pkg::reg_sel_t s);
        if (i_ex_regf_we && (s != 5'd0) && (s == i_ex_rd_s)) begin
            return i_ex_rd_v;
        end
        if (i_wb_regf_we && (s != 5'd0) && (s == i_wb_rd_s)) begin
            return i_wb_rd_v;
        end
        return shadow[s];
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] = '0;
            end
            exp_rec = '0;
            exp_name = "reset";
            exp_row = 1'b0;
            replay = 1'b0;
        end else begin
            if (i_id_ex !== exp_rec) begin
                $display("[FAIL] %0s: id_ex expected %h, actual %h", exp_name, exp_rec, i_id_ex);
                o_errors++;
            end
            if (exp_row) begin
                o_checks++;
            end
            if (i_stall !== i_exp_stall) begin
                $display("[FAIL] %0s: stall expected %0b, actual %0b", i_name, i_exp_stall,
                         i_stall);
                o_errors++;
            end
            cur_word = replay ? held_word : (i_imem_resp ? i_imem_rdata : '0);
            cur_fetch = replay ? held_fetch : (i_imem_resp ? i_if_id : '0);
            cur_rec = decode_rules(cur_word);
            cur_rec.fetch = cur_fetch;
            cur_rec.rs1_v = operand(cur_word[19:15]);
            cur_rec.rs2_v = operand(cur_word[24:20]);
            if (i_exp_stall || i_flush || !(replay || i_imem_resp)) begin
                cur_rec = '0;
            end
            // Word seen during a stall comes back in the next cycle
            if (i_imem_resp && !replay) begin
                held_word = i_imem_rdata;
                held_fetch = i_if_id;
            end
            replay = i_exp_stall && !i_flush;
            if (i_wb_regf_we && (i_wb_rd_s != 5'd0)) begin
                shadow[i_wb_rd_s] = i_wb_rd_v;
            end
            exp_rec = cur_rec;
            exp_name = i_name;
            exp_row = i_row_active;
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_decode_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_decode_top;

    localparam int op_imm   = int'(rv32i_isa_pkg::op_imm);
    localparam int op_reg   = int'(rv32i_isa_pkg::op_reg);
    localparam int op_load  = int'(rv32i_isa_pkg::op_load);
    localparam int op_store = int'(rv32i_isa_pkg::op_store);

    // One cycle of stimulus and the stall expected in that cycle
    typedef struct packed {
        logic [127:0]            name;
        rv32i_isa_pkg::word_t    word;
        logic                    resp;
        logic                    wb_we;
        rv32i_isa_pkg::reg_sel_t wb_rd;
        logic                    ex_we;
        rv32i_isa_pkg::reg_sel_t ex_rd;
        logic                    flush;
        logic                    stall;
    } row_t;

    logic                       clk;
    logic                       rst;
    rv32i_pipe_pkg::if_id_rec_t if_id;
    logic                       imem_resp;
    rv32i_isa_pkg::word_t       imem_rdata;
    rv32i_isa_pkg::reg_sel_t    wb_rd_s;
    rv32i_isa_pkg::word_t       wb_rd_v;
    logic                       wb_regf_we;
    rv32i_isa_pkg::reg_sel_t    ex_rd_s;
    rv32i_isa_pkg::word_t       ex_rd_v;
    logic                       ex_regf_we;
    logic                       flush;
    rv32i_pipe_pkg::id_ex_rec_t id_ex;
    logic                       stall;
    logic [127:0]               row_name;
    logic                       row_active;
    logic                       row_stall;
    int                         errors;
    int                         checks;
    int                         wait_cycles;
    integer                     seed;
    row_t                       rows [$];
    rv32i_isa_pkg::opcode_t     ops [9] = '{
        rv32i_isa_pkg::op_lui, rv32i_isa_pkg::op_auipc, rv32i_isa_pkg::op_imm,
        rv32i_isa_pkg::op_reg, rv32i_isa_pkg::op_load, rv32i_isa_pkg::op_store,
        rv32i_isa_pkg::op_jal, rv32i_isa_pkg::op_jalr, rv32i_isa_pkg::op_br
    };

    decode_top #(
        .NUM_REGS (32)
    ) u_decode_top (
        .clk          (clk),
        .rst          (rst),
        .i_if_id      (if_id),
        .i_imem_resp  (imem_resp),
        .i_imem_rdata (imem_rdata),
        .i_wb_rd_s    (wb_rd_s),
        .i_wb_rd_v    (wb_rd_v),
        .i_wb_regf_we (wb_regf_we),
        .i_ex_rd_s    (ex_rd_s),
        .i_ex_rd_v    (ex_rd_v),
        .i_ex_regf_we (ex_regf_we),
        .i_flush      (flush),
        .o_id_ex      (id_ex),
        .o_stall      (stall)
    );

    decode_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .i_name       (row_name),
        .i_row_active (row_active),
        .i_exp_stall  (row_stall),
        .i_if_id      (if_id),
        .i_imem_resp  (imem_resp),
        .i_imem_rdata (imem_rdata),
        .i_wb_rd_s    (wb_rd_s),
        .i_wb_rd_v    (wb_rd_v),
        .i_wb_regf_we (wb_regf_we),
        .i_ex_rd_s    (ex_rd_s),
        .i_ex_rd_v    (ex_rd_v),
        .i_ex_regf_we (ex_regf_we),
        .i_flush      (flush),
        .i_id_ex      (id_ex),
        .i_stall      (stall),
        .o_errors     (errors),
        .o_checks     (checks)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic rv32i_isa_pkg::word_t encode_fields(input int f7, input int rs2,
                                                           input int rs1, input int f3,
                                                           input int rd, input int op);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'(op)};
    endfunction

    task automatic add_row(input logic [127:0] name, input rv32i_isa_pkg::word_t w,
                           input int resp, input int wb_we, input int wb_rd,
                           input int ex_we, input int ex_rd, input int fl, input int st);
        row_t r;
        r.name = name;
        r.word = w;
        r.resp = 1'(resp);
        r.wb_we = 1'(wb_we);
        r.wb_rd = 5'(wb_rd);
        r.ex_we = 1'(ex_we);
        r.ex_rd = 5'(ex_rd);
        r.flush = 1'(fl);
        r.stall = 1'(st);
        rows.push_back(r);
    endtask

    task automatic build_table();
        rv32i_isa_pkg::word_t w;
        // Random words of every opcode with an idle cycle after each
        for (int rep = 0; rep < 8; rep++) begin
            for (int k = 0; k < 9; k++) begin
                w = $random(seed);
                w[6:0] = ops[k];
                add_row("random_op", w, 1, $random(seed), $random(seed), 0, 0, 0, 0);
                add_row("random_idle", '0, 0, 0, 0, 0, 0, 0, 0);
            end
        end
        // Every funct3 of the ALU, load and store classes
        // Loads write x0 so nothing after them stalls
        for (int f3 = 0; f3 < 8; f3++) begin
            add_row("load_width", encode_fields(0, 0, 1, f3, 0, op_load), 1, 0, 0, 0, 0, 0, 0);
            add_row("store_width", encode_fields(0, 3, 1, f3, 4, op_store), 1, 0, 0, 0, 0, 0, 0);
            add_row("alu_reg", encode_fields(0, 2, 1, f3, 3, op_reg), 1, 0, 0, 0, 0, 0, 0);
            add_row("alu_reg_f7", encode_fields(32, 2, 1, f3, 3, op_reg), 1, 0, 0, 0, 0, 0, 0);
            add_row("alu_imm_f7", encode_fields(32, 2, 1, f3, 3, op_imm), 1, 0, 0, 0, 0, 0, 0);
        end
        add_row("wb_x5", '0, 0, 1, 5, 0, 0, 0, 0);
        add_row("read_x5", encode_fields(0, 5, 5, 0, 6, op_reg), 1, 0, 0, 0, 0, 0, 0);
        add_row("wb_through", encode_fields(0, 7, 7, 0, 6, op_reg), 1, 1, 7, 0, 0, 0, 0);
        add_row("x0_write", encode_fields(0, 0, 0, 0, 6, op_reg), 1, 1, 0, 0, 0, 0, 0);
        add_row("ex_fwd", encode_fields(0, 10, 9, 0, 6, op_reg), 1, 0, 0, 1, 9, 0, 0);
        add_row("ex_fwd_x0", encode_fields(0, 0, 0, 0, 6, op_reg), 1, 0, 0, 1, 0, 0, 0);
        // Load then a dependent instruction on rs1, then on rs2
        add_row("load_x8", encode_fields(0, 0, 1, 2, 8, op_load), 1, 0, 0, 0, 0, 0, 0);
        add_row("use_rs1_x8", encode_fields(0, 2, 8, 0, 11, op_reg), 1, 0, 0, 0, 0, 0, 1);
        add_row("replay_rs1", '0, 0, 0, 0, 0, 0, 0, 0);
        add_row("load_x13", encode_fields(0, 0, 1, 4, 13, op_load), 1, 0, 0, 0, 0, 0, 0);
        add_row("use_rs2_x13", encode_fields(32, 13, 3, 0, 14, op_reg), 1, 0, 0, 0, 0, 0, 1);
        add_row("replay_rs2", '0, 0, 0, 0, 0, 0, 0, 0);
        add_row("flush_add", encode_fields(0, 2, 1, 0, 3, op_reg), 1, 0, 0, 0, 0, 1, 0);
        add_row("load_x12", encode_fields(0, 0, 1, 2, 12, op_load), 1, 0, 0, 0, 0, 0, 0);
        add_row("use_flush", encode_fields(0, 12, 4, 0, 5, op_reg), 1, 0, 0, 0, 0, 1, 1);
        add_row("after_flush", '0, 0, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic apply_row(input int idx);
        row_t                       r;
        rv32i_pipe_pkg::if_id_rec_t f;
        r = rows[idx];
        f.pc = $random(seed);
        f.pc[1:0] = 2'b00;
        f.pc_next = f.pc + 32'd4;
        f.order = 64'(idx);
        f.valid = r.resp;
        if_id <= f;
        imem_resp <= r.resp;
        imem_rdata <= r.word;
        wb_regf_we <= r.wb_we;
        wb_rd_s <= r.wb_rd;
        wb_rd_v <= $random(seed);
        ex_regf_we <= r.ex_we;
        ex_rd_s <= r.ex_rd;
        ex_rd_v <= $random(seed);
        flush <= r.flush;
        row_name <= r.name;
        row_stall <= r.stall;
        row_active <= 1'b1;
    endtask

    initial begin
        seed = 93635;
        rst <= 1'b1;
        if_id <= '0;
        imem_resp <= 1'b0;
        imem_rdata <= '0;
        wb_rd_s <= '0;
        wb_rd_v <= '0;
        wb_regf_we <= 1'b0;
        ex_rd_s <= '0;
        ex_rd_v <= '0;
        ex_regf_we <= 1'b0;
        flush <= 1'b0;
        row_name <= "reset";
        row_active <= 1'b0;
        row_stall <= 1'b0;
        build_table();
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
        end
        rst <= 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            apply_row(i);
        end
        @(posedge clk);
        imem_resp <= 1'b0;
        wb_regf_we <= 1'b0;
        ex_regf_we <= 1'b0;
        flush <= 1'b0;
        row_name <= "drain";
        row_stall <= 1'b0;
        row_active <= 1'b0;
        // Last records reach the checker a cycle or two later
        for (wait_cycles = 0; (checks < rows.size()) && (wait_cycles < 20); wait_cycles++) begin
            @(negedge clk);
        end
        $display("checks %0d of %0d, errors %0d", checks, rows.size(), errors);
        if (checks < rows.size()) begin
            $display("Timed out waiting for the checker to compare the last records");
            $display("TEST RESULT: FAIL");
        end else if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
